/* bench/pc_ctrl_assertions.sv */
`timescale 1ns/1ps

module pc_ctrl_assertions import fetch_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       bubble_i,
	input logic       misprediction_i,
	input logic       secure_mode_i,
	input logic       seu_inject_i,
	input addr_t      inst_addr_i  [FETCH_WIDTH],
	input addr_t      current_pc_i [FETCH_WIDTH],
	input logic       mismatch_i,
	input copy_mask_t copy_error_i,
	input logic       fatal_error_i
);

	// Failure tally, read by the testbench
	int unsigned fail_count = 0;

	////////////////////////////////////////
	// Slot strides
	////////////////////////////////////////
	genvar k;
	generate
		for (k = 1; k < FETCH_WIDTH; k++) begin : g_stride
			a_inst_stride: assert property (@(posedge clk)
				inst_addr_i[k] == inst_addr_i[0] + addr_t'(INST_BYTES * k))
			else begin
				$error("inst_addr slot %0d is off the 4-byte stride", k);
				fail_count++;
			end
			a_pc_stride: assert property (@(posedge clk)
				current_pc_i[k] == current_pc_i[0] + addr_t'(INST_BYTES * k))
			else begin
				$error("current_pc slot %0d is off the 4-byte stride", k);
				fail_count++;
			end
		end
	endgenerate

	////////////////////////////////////////
	// Reset, stall and scrub rules
	////////////////////////////////////////
	a_reset_values: assert property (@(posedge clk)
		!reset |-> inst_addr_i[0] == RESET_PC && !mismatch_i && copy_error_i == '0 && !fatal_error_i)
	else begin
		$error("Boot address or fault flags wrong during reset");
		fail_count++;
	end

	// Held group is refetched
	a_stall_refetch: assert property (@(posedge clk) disable iff (!reset)
		bubble_i && !misprediction_i |-> inst_addr_i[0] == current_pc_i[0])
	else begin
		$error("Stalled fetch address differs from the held PC");
		fail_count++;
	end

	a_scrub_clears: assert property (@(posedge clk) disable iff (!reset)
		bubble_i && !misprediction_i && secure_mode_i && mismatch_i && !seu_inject_i
		|=> !mismatch_i)
	else begin
		$error("Mismatch still present after a scrub edge");
		fail_count++;
	end

endmodule

bind pc_ctrl_top pc_ctrl_assertions u_checks (
	.clk             (clk),
	.reset           (reset),
	.bubble_i        (bubble_i),
	.misprediction_i (misprediction_i),
	.secure_mode_i   (secure_mode_i),
	.seu_inject_i    (seu_inject_i),
	.inst_addr_i     (inst_addr_o),
	.current_pc_i    (current_pc_o),
	.mismatch_i      (mismatch_o),
	.copy_error_i    (copy_error_o),
	.fatal_error_i   (fatal_error_o)
);

/* bench/tb_pc_ctrl.sv */
`timescale 1ns/1ps

module tb_pc_ctrl import fetch_pkg::*; ();

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 4;
	localparam int SEQ_CYCLES      = 20;
	localparam int REDIRECT_CYCLES = 200;
	localparam int STALL_CYCLES    = 60;
	localparam int FAULT_CYCLES    = 20;
	localparam int MARGIN_CYCLES   = 20;

	logic       clk = 1'b0;
	logic       reset;
	logic       bubble_i;
	logic       misprediction_i;
	addr_t      correct_pc_i;
	slot_mask_t jump_i;
	slot_mask_t jalr_i;
	addr_t      imm_i [FETCH_WIDTH];
	logic       jalr_pred_valid_i;
	addr_t      jalr_pred_target_i;
	logic       secure_mode_i;
	logic       seu_inject_i;
	copy_sel_t  seu_copy_i;
	addr_t      seu_mask_i;
	addr_t      inst_addr_o  [FETCH_WIDTH];
	addr_t      current_pc_o [FETCH_WIDTH];
	addr_t      pc_save_o    [FETCH_WIDTH];
	logic       mismatch_o;
	copy_mask_t copy_error_o;
	logic       fatal_error_o;

	// Reference state
	addr_t      model_pc;
	logic       exp_mismatch;
	copy_mask_t exp_copy_error;
	logic       exp_fatal;

	always #(CLK_PERIOD / 2) clk = ~clk;

	pc_ctrl_top UUT (.*);

	task automatic stop_on_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic expect_value(string name, logic [XLEN-1:0] actual, logic [XLEN-1:0] expected);
		assert (actual === expected) else begin
			$display("[ERROR] t=%0t %s: actual %h, expected %h", $time, name, actual, expected);
			stop_on_failure();
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic addr_t predict_next(addr_t pc);
		if (misprediction_i)
			return correct_pc_i;
		if (bubble_i)
			return pc;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			if (jump_i[k])
				return pc + addr_t'(INST_BYTES * k) + (imm_i[k] & ~addr_t'(INST_BYTES - 1));
			if (jalr_i[k])
				return jalr_pred_valid_i ? jalr_pred_target_i : pc + addr_t'(INST_BYTES * (k + 1));
		end
		return pc + addr_t'(FETCH_STRIDE);
	endfunction

	task automatic compare_outputs();
		addr_t base;
		addr_t slot;
		addr_t save;
		base = (misprediction_i || !bubble_i) ? predict_next(model_pc) : model_pc;
		if (!reset)
			base = RESET_PC;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			slot = model_pc + addr_t'(INST_BYTES * k);
			save = (jump_i[k] || jalr_i[k]) ? slot + addr_t'(INST_BYTES)
			                                 : slot + (imm_i[k] & ~addr_t'(INST_BYTES - 1));
			expect_value($sformatf("current_pc_o[%0d]", k), current_pc_o[k], slot);
			expect_value($sformatf("inst_addr_o[%0d]", k), inst_addr_o[k],
			             base + addr_t'(INST_BYTES * k));
			expect_value($sformatf("pc_save_o[%0d]", k), pc_save_o[k], save);
		end
		expect_value("mismatch_o", mismatch_o, exp_mismatch);
		expect_value("copy_error_o", copy_error_o, exp_copy_error);
		expect_value("fatal_error_o", fatal_error_o, exp_fatal);
	endtask

	// Check mid-cycle, step the model at the edge, drive 2 ns later
	task automatic run_cycle();
		addr_t next_pc;
		@(negedge clk);
		compare_outputs();
		next_pc = reset ? predict_next(model_pc) : RESET_PC;
		@(posedge clk);
		model_pc = next_pc;
		#2;
	endtask

	task automatic expect_flags(logic mismatch, copy_mask_t copy_err, logic fatal);
		exp_mismatch   = mismatch;
		exp_copy_error = copy_err;
		exp_fatal      = fatal;
	endtask

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	task automatic drive_idle();
		bubble_i           = 1'b0;
		misprediction_i    = 1'b0;
		correct_pc_i       = '0;
		jump_i             = '0;
		jalr_i             = '0;
		jalr_pred_valid_i  = 1'b0;
		jalr_pred_target_i = '0;
		seu_inject_i       = 1'b0;
		seu_copy_i         = '0;
		seu_mask_i         = '0;
		foreach (imm_i[k])
			imm_i[k] = '0;
	endtask

	// Sparse masks so some groups fall through
	task automatic drive_random_flow();
		jump_i             = slot_mask_t'($urandom) & slot_mask_t'($urandom);
		jalr_i             = slot_mask_t'($urandom) & slot_mask_t'($urandom);
		jalr_pred_valid_i  = 1'($urandom);
		jalr_pred_target_i = $urandom & ~addr_t'(3);
		foreach (imm_i[k])
			imm_i[k] = $urandom;
	endtask

	task automatic upset_cycle(logic stall, copy_sel_t copy, addr_t mask);
		drive_idle();
		bubble_i     = stall;
		seu_inject_i = 1'b1;
		seu_copy_i   = copy;
		seu_mask_i   = mask;
		run_cycle();
	endtask

	task automatic upset_and_scrub(copy_sel_t copy);
		upset_cycle(1'b1, copy, $urandom | 32'h1);
		drive_idle();
		bubble_i = 1'b1;
		expect_flags(1'b1, copy_mask_t'(1 << copy), 1'b0);
		run_cycle();
		expect_flags(1'b0, '0, 1'b0);
		run_cycle();
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(62));
		reset         = 1'b0;
		secure_mode_i = 1'b1;
		model_pc      = RESET_PC;
		drive_idle();
		expect_flags(1'b0, '0, 1'b0);
		repeat (RESET_CYCLES) run_cycle();
		reset = 1'b1;

		repeat (SEQ_CYCLES) run_cycle();

		repeat (REDIRECT_CYCLES) begin
			drive_random_flow();
			run_cycle();
		end

		// Correction wins over a bubble
		drive_idle();
		bubble_i        = 1'b1;
		misprediction_i = 1'b1;
		correct_pc_i    = 32'h8000_4000;
		run_cycle();
		repeat (STALL_CYCLES - 1) begin
			drive_random_flow();
			bubble_i        = ($urandom % 3) == 0;
			misprediction_i = ($urandom % 6) == 0;
			correct_pc_i    = $urandom & ~addr_t'(3);
			run_cycle();
		end

		for (int c = 0; c < TMR_COPIES; c++)
			upset_and_scrub(copy_sel_t'(c));

		// Copy 0 carries the PC when voting is off
		secure_mode_i = 1'b0;
		upset_cycle(1'b1, 2'd1, $urandom | 32'h1);
		upset_cycle(1'b1, 2'd2, $urandom | 32'h1);
		drive_idle();
		bubble_i = 1'b1;
		run_cycle();
		drive_idle();
		run_cycle();

		// Two upsets on different bits already leave no agreeing pair
		secure_mode_i = 1'b1;
		upset_cycle(1'b1, 2'd0, 32'h0000_0100);
		expect_flags(1'b1, 3'b001, 1'b0);
		upset_cycle(1'b1, 2'd1, 32'h0001_0000);
		expect_flags(1'b1, 3'b011, 1'b1);
		upset_cycle(1'b1, 2'd2, 32'h0100_0000);
		expect_flags(1'b1, 3'b111, 1'b1);
		drive_idle();
		run_cycle();
		expect_flags(1'b0, '0, 1'b0);
		run_cycle();

		if (UUT.u_checks.fail_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Bound assertion failures were recorded");
			stop_on_failure();
		end
	end

	always @(UUT.u_checks.fail_count) begin
		if (UUT.u_checks.fail_count != 0) begin
			$display("A bound assertion failed");
			stop_on_failure();
		end
	end

	initial begin
		#((RESET_CYCLES + SEQ_CYCLES + REDIRECT_CYCLES + STALL_CYCLES + FAULT_CYCLES
		   + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the test sequence finished");
		stop_on_failure();
	end

endmodule

/* logic/fetch_addr_gen.sv */
`timescale 1ns/1ps

module fetch_addr_gen import fetch_pkg::*; (
	input  logic       reset,
	input  logic       bubble_i,
	input  logic       misprediction_i,
	input  addr_t      pc_voted_i,
	input  addr_t      next_pc_i,
	input  slot_mask_t jump_i,
	input  slot_mask_t jalr_i,
	input  addr_t      imm_i        [FETCH_WIDTH],
	output addr_t      inst_addr_o  [FETCH_WIDTH],
	output addr_t      current_pc_o [FETCH_WIDTH],
	output addr_t      pc_save_o    [FETCH_WIDTH]
);

	addr_t fetch_base;
	addr_t link_val  [FETCH_WIDTH];
	addr_t auipc_val [FETCH_WIDTH];

	////////////////////////////////////////
	// Fetch group base address
	////////////////////////////////////////
	always_comb begin
		if (!reset) begin
			fetch_base = RESET_PC;
		end else if (misprediction_i || !bubble_i) begin
			// Look ahead to the address being loaded this edge
			fetch_base = next_pc_i;
		end else begin
			// Stalled, refetch the held group
			fetch_base = pc_voted_i;
		end
	end

	////////////////////////////////////////
	// Per-slot outputs
	////////////////////////////////////////
	genvar k;
	generate
		for (k = 0; k < FETCH_WIDTH; k++) begin : g_slot
			assign inst_addr_o[k]  = fetch_base + addr_t'(INST_BYTES * k);
			assign current_pc_o[k] = pc_voted_i + addr_t'(INST_BYTES * k);

			// Return address for JAL and JALR
			assign link_val[k] = current_pc_o[k] + addr_t'(INST_BYTES);

			// AUIPC result, low bits of the immediate dropped
			assign auipc_val[k] = current_pc_o[k] + {imm_i[k][XLEN-1:2], 2'b00};

			assign pc_save_o[k] = (jump_i[k] || jalr_i[k]) ? link_val[k] : auipc_val[k];
		end
	endgenerate

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	localparam int XLEN        = 32;
	localparam int FETCH_WIDTH = 5;
	localparam int INST_BYTES  = 4;
	localparam int TMR_COPIES  = 3;

	// Sequential advance of a whole fetch group
	localparam int FETCH_STRIDE = FETCH_WIDTH * INST_BYTES;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////
	typedef logic [XLEN-1:0]        addr_t;
	typedef logic [FETCH_WIDTH-1:0] slot_mask_t;
	typedef logic [TMR_COPIES-1:0]  copy_mask_t;
	typedef logic [1:0]             copy_sel_t;

	// Boot address
	localparam addr_t RESET_PC = 32'h8000_0000;

endpackage

/* logic/pc_ctrl_top.sv */
`timescale 1ns/1ps

module pc_ctrl_top import fetch_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       bubble_i,
	input  logic       misprediction_i,
	input  addr_t      correct_pc_i,
	input  slot_mask_t jump_i,
	input  slot_mask_t jalr_i,
	input  addr_t      imm_i [FETCH_WIDTH],
	input  logic       jalr_pred_valid_i,
	input  addr_t      jalr_pred_target_i,
	input  logic       secure_mode_i,
	input  logic       seu_inject_i,
	input  copy_sel_t  seu_copy_i,
	input  addr_t      seu_mask_i,
	output addr_t      inst_addr_o  [FETCH_WIDTH],
	output addr_t      current_pc_o [FETCH_WIDTH],
	output addr_t      pc_save_o    [FETCH_WIDTH],
	output logic       mismatch_o,
	output copy_mask_t copy_error_o,
	output logic       fatal_error_o
);

	addr_t pc_voted;
	addr_t next_pc;
	logic  redirect_valid;
	addr_t redirect_target;

	////////////////////////////////////////
	// Control-flow scan
	////////////////////////////////////////
	slot_redirect u_redirect (
		.pc_voted_i         (pc_voted),
		.jump_i             (jump_i),
		.jalr_i             (jalr_i),
		.imm_i              (imm_i),
		.jalr_pred_valid_i  (jalr_pred_valid_i),
		.jalr_pred_target_i (jalr_pred_target_i),
		.redirect_valid_o   (redirect_valid),
		.redirect_target_o  (redirect_target)
	);

	////////////////////////////////////////
	// Protected PC state
	////////////////////////////////////////
	pc_tmr_reg u_pc (
		.clk               (clk),
		.reset             (reset),
		.bubble_i          (bubble_i),
		.misprediction_i   (misprediction_i),
		.correct_pc_i      (correct_pc_i),
		.secure_mode_i     (secure_mode_i),
		.redirect_valid_i  (redirect_valid),
		.redirect_target_i (redirect_target),
		.seu_inject_i      (seu_inject_i),
		.seu_copy_i        (seu_copy_i),
		.seu_mask_i        (seu_mask_i),
		.pc_voted_o        (pc_voted),
		.next_pc_o         (next_pc),
		.mismatch_o        (mismatch_o),
		.copy_error_o      (copy_error_o),
		.fatal_error_o     (fatal_error_o)
	);

	// Fetch addresses and slot values
	fetch_addr_gen u_addr (
		.reset           (reset),
		.bubble_i        (bubble_i),
		.misprediction_i (misprediction_i),
		.pc_voted_i      (pc_voted),
		.next_pc_i       (next_pc),
		.jump_i          (jump_i),
		.jalr_i          (jalr_i),
		.imm_i           (imm_i),
		.inst_addr_o     (inst_addr_o),
		.current_pc_o    (current_pc_o),
		.pc_save_o       (pc_save_o)
	);

endmodule

/* logic/pc_tmr_reg.sv */
`timescale 1ns/1ps

module pc_tmr_reg import fetch_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       bubble_i,
	input  logic       misprediction_i,
	input  addr_t      correct_pc_i,
	input  logic       secure_mode_i,
	input  logic       redirect_valid_i,
	input  addr_t      redirect_target_i,
	input  logic       seu_inject_i,
	input  copy_sel_t  seu_copy_i,
	input  addr_t      seu_mask_i,
	output addr_t      pc_voted_o,
	output addr_t      next_pc_o,
	output logic       mismatch_o,
	output copy_mask_t copy_error_o,
	output logic       fatal_error_o
);

	addr_t pc_copy [TMR_COPIES];
	logic  advance;

	// Correction beats redirect, redirect beats stride
	assign next_pc_o = misprediction_i  ? correct_pc_i      :
	                   redirect_valid_i ? redirect_target_i :
	                   pc_voted_o + addr_t'(FETCH_STRIDE);

	// A correction goes through even while stalled
	assign advance = misprediction_i || !bubble_i;

	////////////////////////////////////////
	// Redundant PC copies
	////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int k = 0; k < TMR_COPIES; k++) begin
				pc_copy[k] <= RESET_PC;
			end
		end else if (advance) begin
			// Same value into every copy, heals any upset
			for (int k = 0; k < TMR_COPIES; k++) begin
				pc_copy[k] <= next_pc_o;
			end
		end else if (seu_inject_i) begin
			// Upset on the selected copy, others hold
			for (int k = 0; k < TMR_COPIES; k++) begin
				if (seu_copy_i == copy_sel_t'(k)) begin
					pc_copy[k] <= pc_copy[k] ^ seu_mask_i;
				end
			end
		end else if (secure_mode_i && mismatch_o) begin
			// Scrub while stalled
			for (int k = 0; k < TMR_COPIES; k++) begin
				pc_copy[k] <= pc_voted_o;
			end
		end
	end

	tmr_voter u_voter (
		.secure_mode_i (secure_mode_i),
		.copy_i        (pc_copy),
		.voted_o       (pc_voted_o),
		.mismatch_o    (mismatch_o),
		.copy_error_o  (copy_error_o),
		.fatal_error_o (fatal_error_o)
	);

endmodule

/* logic/slot_redirect.sv */
`timescale 1ns/1ps

module slot_redirect import fetch_pkg::*; (
	input  addr_t      pc_voted_i,
	input  slot_mask_t jump_i,
	input  slot_mask_t jalr_i,
	input  addr_t      imm_i [FETCH_WIDTH],
	input  logic       jalr_pred_valid_i,
	input  addr_t      jalr_pred_target_i,
	output logic       redirect_valid_o,
	output addr_t      redirect_target_o
);

	addr_t slot_pc     [FETCH_WIDTH];
	addr_t jal_target  [FETCH_WIDTH];
	addr_t jalr_target [FETCH_WIDTH];
	addr_t slot_target [FETCH_WIDTH];

	////////////////////////////////////////
	// Per-slot target candidates
	////////////////////////////////////////
	genvar k;
	generate
		for (k = 0; k < FETCH_WIDTH; k++) begin : g_slot
			// Slot PC is the group base plus the slot offset
			assign slot_pc[k] = pc_voted_i + addr_t'(INST_BYTES * k);

			// JAL target, immediate word aligned
			assign jal_target[k] = slot_pc[k] + {imm_i[k][XLEN-1:2], 2'b00};

			// JALR falls through when the predictor has nothing
			assign jalr_target[k] = jalr_pred_valid_i ? jalr_pred_target_i
			                                          : slot_pc[k] + addr_t'(INST_BYTES);

			// A slot flagged as both is treated as a jump
			assign slot_target[k] = jump_i[k] ? jal_target[k] : jalr_target[k];
		end
	endgenerate

	////////////////////////////////////////
	// Priority pick, lowest slot wins
	////////////////////////////////////////
	always_comb begin
		redirect_valid_o  = 1'b0;
		redirect_target_o = '0;
		// Walk from the top slot down so the lowest flagged slot overrides
		for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
			if (jump_i[i] || jalr_i[i]) begin
				redirect_valid_o  = 1'b1;
				redirect_target_o = slot_target[i];
			end
		end
	end

endmodule

/* logic/tmr_voter.sv */
`timescale 1ns/1ps

module tmr_voter import fetch_pkg::*; (
	input  logic       secure_mode_i,
	input  addr_t      copy_i [TMR_COPIES],
	output addr_t      voted_o,
	output logic       mismatch_o,
	output copy_mask_t copy_error_o,
	output logic       fatal_error_o
);

	addr_t      majority;
	copy_mask_t differs;
	logic       all_distinct;

	// Bitwise two-out-of-three
	assign majority = (copy_i[0] & copy_i[1]) |
	                  (copy_i[0] & copy_i[2]) |
	                  (copy_i[1] & copy_i[2]);

	genvar k;
	generate
		for (k = 0; k < TMR_COPIES; k++) begin : g_cmp
			assign differs[k] = (copy_i[k] != majority);
		end
	endgenerate

	// No two copies agree, the vote means nothing
	assign all_distinct = (copy_i[0] != copy_i[1]) &&
	                      (copy_i[0] != copy_i[2]) &&
	                      (copy_i[1] != copy_i[2]);

	////////////////////////////////////////
	// Mode select
	////////////////////////////////////////
	always_comb begin
		if (secure_mode_i) begin
			voted_o       = majority;
			copy_error_o  = differs;
			mismatch_o    = |differs;
			fatal_error_o = all_distinct;
		end else begin
			// Plain register behaviour, copy 0 only
			voted_o       = copy_i[0];
			copy_error_o  = '0;
			mismatch_o    = 1'b0;
			fatal_error_o = 1'b0;
		end
	end

endmodule

/* tb.f */
logic/fetch_pkg.sv
logic/slot_redirect.sv
logic/tmr_voter.sv
logic/pc_tmr_reg.sv
logic/fetch_addr_gen.sv
logic/pc_ctrl_top.sv
bench/pc_ctrl_assertions.sv
bench/tb_pc_ctrl.sv
